/* hw/alu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_core (
    input  wire                               clk,
    input  wire                               arst_n,
    input  wire                               dec_valid,
    input  wire  avr_isa_pkg::avr_insn_t      dec,
    output logic                              dec_ready,
    output logic [avr_dp_pkg::REG_ADDR_W-1:0] rd_addr,
    output logic [avr_dp_pkg::REG_ADDR_W-1:0] rr_addr,
    input  wire  [avr_dp_pkg::REG_DATA_W-1:0] rd_rdata,
    input  wire  [avr_dp_pkg::REG_DATA_W-1:0] rr_rdata,
    output logic                              we,
    output logic [avr_dp_pkg::REG_ADDR_W-1:0] waddr,
    output logic [avr_dp_pkg::REG_DATA_W-1:0] wdata,
    output logic                              res_valid,
    output avr_dp_pkg::avr_result_t           res,
    input  wire                               res_ready
);
    import avr_isa_pkg::*;
    import avr_dp_pkg::*;

    logic                  a_valid_q;              // Stage A occupied.
    avr_insn_t             a_insn_q;
    logic                  b_valid_q;              // Stage B occupied, operands on the read ports.
    avr_insn_t             b_insn_q;
    avr_flags_t            flags_q;                // Architectural C, Z, N.
    avr_flags_t            flags_nxt;
    logic [REG_DATA_W:0]   wide;                   // Result with carry or borrow on top.
    logic [REG_DATA_W-1:0] value;
    logic                  b_is_nop;
    logic                  b_fire;                 // B retires at this edge.
    logic                  b_load;                 // A moves into B at this edge.

    assign b_is_nop  = (b_insn_q.op == NOP_ILLEGAL);
    assign res_valid = b_valid_q && !b_is_nop;     // Illegal words leave without a result.
    assign b_fire    = b_valid_q && (b_is_nop || res_ready);
    assign b_load    = a_valid_q && (!b_valid_q || b_fire);
    assign dec_ready = !a_valid_q || b_load;

    // Present the addresses of whatever occupies B after the edge.
    // During a stall that re-registers B's own read.
    assign rd_addr = b_load ? a_insn_q.rd : b_insn_q.rd;
    assign rr_addr = b_load ? a_insn_q.rr : b_insn_q.rr;

    always_comb begin
        flags_nxt = flags_q;
        case (b_insn_q.op)
            ADD:     wide = {1'b0, rd_rdata} + {1'b0, rr_rdata};
            ADC:     wide = {1'b0, rd_rdata} + {1'b0, rr_rdata} + {{REG_DATA_W{1'b0}}, flags_q.c};
            SUB:     wide = {1'b0, rd_rdata} - {1'b0, rr_rdata};    // Top bit is the borrow.
            AND:     wide = {1'b0, rd_rdata & rr_rdata};
            OR:      wide = {1'b0, rd_rdata | rr_rdata};
            EOR:     wide = {1'b0, rd_rdata ^ rr_rdata};
            MOV:     wide = {1'b0, rr_rdata};
            LDI:     wide = {1'b0, b_insn_q.imm};
            default: wide = '0;
        endcase
        value = wide[REG_DATA_W-1:0];
        // MOV and LDI keep every flag.
        if (b_insn_q.op inside {ADD, ADC, SUB, AND, OR, EOR}) begin
            flags_nxt.c = wide[REG_DATA_W];        // Always zero for the logic group.
            flags_nxt.z = (value == '0);
            flags_nxt.n = value[REG_DATA_W-1];
        end
    end

    assign res   = '{rd: b_insn_q.rd, value: value, flags: flags_nxt};
    assign we    = res_valid && res_ready;         // Write back only when the queue takes it.
    assign waddr = b_insn_q.rd;
    assign wdata = value;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_valid_q <= 1'b0;
            b_valid_q <= 1'b0;
            flags_q   <= '0;
        end else begin
            if (dec_ready) begin
                a_valid_q <= dec_valid;
            end
            if (b_load) begin
                b_valid_q <= 1'b1;
            end else if (b_fire) begin
                b_valid_q <= 1'b0;
            end
            if (we) begin
                flags_q <= flags_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && dec_ready) begin
            a_insn_q <= dec;
        end
        if (b_load) begin
            b_insn_q <= a_insn_q;
        end
    end

    // A stalled result does not drift, so the held read address stays good.
    a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid && !res_ready |=> res_valid && $stable(res))
        else $error("alu_core: result changed during a stall.");

endmodule

`default_nettype wire

/* hw/avr_dp_pkg.sv */
`default_nettype none

package avr_dp_pkg;

    localparam int REG_ADDR_W = 5;                 // 32 general purpose registers.
    localparam int REG_DATA_W = 8;                 // 8-bit datapath.

    // Status bits kept by this slice.
    typedef struct packed {
        logic c;                                   // Carry, or borrow after SUB.
        logic z;                                   // Result was zero.
        logic n;                                   // Result bit 7.
    } avr_flags_t;

    // One retired instruction as seen at the output.
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;                 // Register that was written.
        logic [REG_DATA_W-1:0] value;              // Value written to rd.
        avr_flags_t            flags;              // Flags after the instruction.
    } avr_result_t;

endpackage

`default_nettype wire

/* hw/avr_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module avr_exec_top #(
    parameter int DATA_WIDTH  = avr_dp_pkg::REG_DATA_W,
    parameter int ADDR_WIDTH  = avr_dp_pkg::REG_ADDR_W,
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                                clk,
    input  wire                                arst_n,
    input  wire                                insn_valid,
    output logic                               insn_ready,
    input  wire  [avr_isa_pkg::INSN_WIDTH-1:0] insn,
    output logic                               out_valid,
    output avr_dp_pkg::avr_result_t            out,
    input  wire                                out_ready
);
    import avr_isa_pkg::*;
    import avr_dp_pkg::*;

    logic                  dec_valid;              // Decoder to core.
    logic                  dec_ready;
    avr_insn_t             dec;
    logic [ADDR_WIDTH-1:0] rd_addr;                // Core to register file.
    logic [ADDR_WIDTH-1:0] rr_addr;
    logic [DATA_WIDTH-1:0] rd_rdata;
    logic [DATA_WIDTH-1:0] rr_rdata;
    logic                  we;
    logic [ADDR_WIDTH-1:0] waddr;
    logic [DATA_WIDTH-1:0] wdata;
    logic                  res_valid;              // Core to output queue.
    logic                  res_ready;
    avr_result_t           res;

    insn_decoder u_dec (
        .clk        (clk),
        .arst_n     (arst_n),
        .insn_valid (insn_valid),
        .insn_ready (insn_ready),
        .insn       (insn),
        .dec_valid  (dec_valid),
        .dec        (dec),
        .dec_ready  (dec_ready)
    );

    alu_core u_core (
        .clk       (clk),
        .arst_n    (arst_n),
        .dec_valid (dec_valid),
        .dec       (dec),
        .dec_ready (dec_ready),
        .rd_addr   (rd_addr),
        .rr_addr   (rr_addr),
        .rd_rdata  (rd_rdata),
        .rr_rdata  (rr_rdata),
        .we        (we),
        .waddr     (waddr),
        .wdata     (wdata),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready)
    );

    dual_port_sram #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_regs (
        .clk      (clk),
        .rd_addr  (rd_addr),
        .rr_addr  (rr_addr),
        .rd_rdata (rd_rdata),
        .rr_rdata (rr_rdata),
        .we       (we),
        .waddr    (waddr),
        .wdata    (wdata)
    );

    result_queue #(
        .DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk       (clk),
        .arst_n    (arst_n),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready),
        .out_valid (out_valid),
        .out       (out),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

/* hw/avr_isa_pkg.sv */
`default_nettype none

package avr_isa_pkg;

    localparam int INSN_WIDTH = 16;                // One AVR instruction word.

    // Operation picked by the decoder.
    typedef enum logic [3:0] {
        NOP_ILLEGAL = 4'd0,                        // Unsupported word, retires silently.
        ADD         = 4'd1,
        ADC         = 4'd2,
        SUB         = 4'd3,
        AND         = 4'd4,
        OR          = 4'd5,
        EOR         = 4'd6,
        MOV         = 4'd7,
        LDI         = 4'd8
    } avr_op_e;

    // Decoded instruction handed from the decoder to the core.
    typedef struct packed {
        avr_op_e    op;
        logic [4:0] rd;                            // Destination and first operand.
        logic [4:0] rr;                            // Second operand.
        logic [7:0] imm;                           // LDI constant.
    } avr_insn_t;

    // Register-register group, compared against bits [15:10].
    localparam logic [5:0] OPC6_ADD = 6'b0000_11;
    localparam logic [5:0] OPC6_ADC = 6'b0001_11;
    localparam logic [5:0] OPC6_SUB = 6'b0001_10;
    localparam logic [5:0] OPC6_AND = 6'b0010_00;
    localparam logic [5:0] OPC6_EOR = 6'b0010_01;
    localparam logic [5:0] OPC6_OR  = 6'b0010_10;
    localparam logic [5:0] OPC6_MOV = 6'b0010_11;

    localparam logic [3:0] OPC4_LDI  = 4'b1110;    // Compared against bits [15:12].
    localparam logic       LDI_RD_HI = 1'b1;       // LDI only reaches r16 to r31.

endpackage

`default_nettype wire

/* hw/dual_port_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_port_sram #(
    parameter int DATA_WIDTH = 8,                  // Register width.
    parameter int ADDR_WIDTH = 5                   // 32 registers.
) (
    input  wire                   clk,
    input  wire  [ADDR_WIDTH-1:0] rd_addr,
    input  wire  [ADDR_WIDTH-1:0] rr_addr,
    output logic [DATA_WIDTH-1:0] rd_rdata,
    output logic [DATA_WIDTH-1:0] rr_rdata,
    input  wire                   we,
    input  wire  [ADDR_WIDTH-1:0] waddr,
    input  wire  [DATA_WIDTH-1:0] wdata
);
    localparam int WORDS = 1 << ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [WORDS];
    logic [ADDR_WIDTH-1:0] rd_addr_q;              // Registered read address, rd port.
    logic [ADDR_WIDTH-1:0] rr_addr_q;              // Registered read address, rr port.
    logic                  rd_byp_q;               // rd port hit the last write.
    logic                  rr_byp_q;               // rr port hit the last write.
    logic [DATA_WIDTH-1:0] byp_data_q;             // Word written at the last edge.

    // Register i powers up holding 255 - i.
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = DATA_WIDTH'(255 - i);
        end
    end

    // Single write port, rising edge.
    always @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Addresses are captured every edge. The caller re-presents one to hold a read.
    always_ff @(posedge clk) begin
        rd_addr_q  <= rd_addr;
        rr_addr_q  <= rr_addr;
        rd_byp_q   <= we && (waddr == rd_addr);    // Write-first on a same-edge collision.
        rr_byp_q   <= we && (waddr == rr_addr);
        byp_data_q <= wdata;
    end

    // Read data comes straight from the registered address.
    assign rd_rdata = rd_byp_q ? byp_data_q : mem[rd_addr_q];
    assign rr_rdata = rr_byp_q ? byp_data_q : mem[rr_addr_q];

endmodule

`default_nettype wire

/* hw/insn_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
    input  wire                                clk,
    input  wire                                arst_n,
    input  wire                                insn_valid,
    output logic                               insn_ready,
    input  wire  [avr_isa_pkg::INSN_WIDTH-1:0] insn,
    output logic                               dec_valid,
    output avr_isa_pkg::avr_insn_t             dec,
    input  wire                                dec_ready
);
    import avr_isa_pkg::*;

    logic                  ready_q;                // Low through reset, then stays high.
    logic                  full_q;                 // One instruction is held.
    logic [INSN_WIDTH-1:0] insn_q;                 // Raw word, decoded on the way out.
    logic                  take;

    // Refill is allowed in the same cycle the held instruction leaves.
    assign insn_ready = ready_q && (!full_q || dec_ready);
    assign take       = insn_valid && insn_ready;
    assign dec_valid  = full_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_q <= 1'b0;
            full_q  <= 1'b0;
        end else begin
            ready_q <= 1'b1;
            if (take) begin
                full_q <= 1'b1;                    // New word replaces or fills.
            end else if (dec_ready) begin
                full_q <= 1'b0;                    // Drained with nothing behind it.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            insn_q <= insn;
        end
    end

    // Field extraction follows the AVR opcode map.
    always_comb begin
        dec     = '0;
        dec.op  = NOP_ILLEGAL;
        dec.rd  = insn_q[8:4];                     // ddddd.
        dec.rr  = {insn_q[9], insn_q[3:0]};        // r rrrr, split across the word.
        dec.imm = 8'h00;
        if (insn_q[15:12] == OPC4_LDI) begin
            dec.op  = LDI;
            dec.rd  = {LDI_RD_HI, insn_q[7:4]};    // 16 + dddd.
            dec.imm = {insn_q[11:8], insn_q[3:0]};
        end else begin
            case (insn_q[15:10])
                OPC6_ADD: dec.op = ADD;
                OPC6_ADC: dec.op = ADC;
                OPC6_SUB: dec.op = SUB;
                OPC6_AND: dec.op = AND;
                OPC6_EOR: dec.op = EOR;
                OPC6_OR:  dec.op = OR;
                OPC6_MOV: dec.op = MOV;
                default:  dec.op = NOP_ILLEGAL;    // Consumed, no result.
            endcase
        end
    end

    // A stalled instruction must not change before the core takes it.
    a_dec_hold: assert property (@(posedge clk) disable iff (!arst_n)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec))
        else $error("insn_decoder: held instruction changed under stall.");

endmodule

`default_nettype wire

/* hw/result_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module result_queue #(
    parameter int DEPTH = 4                        // Power of two.
) (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          res_valid,
    input  wire avr_dp_pkg::avr_result_t res,
    output logic                         res_ready,
    output logic                         out_valid,
    output avr_dp_pkg::avr_result_t      out,
    input  wire                          out_ready
);
    import avr_dp_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    avr_result_t    mem [DEPTH];
    logic [IDX_W:0] wr_ptr_q;                      // Extra top bit tells full from empty.
    logic [IDX_W:0] rd_ptr_q;
    logic [IDX_W:0] pub_ptr_q;                     // Write pointer seen by the read side.
    logic [IDX_W:0] count;
    logic           push;
    logic           pop;

    assign count     = wr_ptr_q - rd_ptr_q;
    assign res_ready = (count != (IDX_W + 1)'(DEPTH));
    assign push      = res_valid && res_ready;
    // An entry becomes visible one cycle after it is written.
    assign out_valid = (pub_ptr_q != rd_ptr_q);
    assign pop       = out_valid && out_ready;
    assign out       = mem[rd_ptr_q[IDX_W-1:0]];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            pub_ptr_q <= '0;
        end else begin
            pub_ptr_q <= wr_ptr_q;
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q[IDX_W-1:0]] <= res;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        count <= (IDX_W + 1)'(DEPTH))
        else $error("result_queue: more entries than slots.");

    // Head entry holds while the consumer stalls.
    a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out))
        else $error("result_queue: head changed under stall.");

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module avr_exec_tb -o avr_exec_sim

output=$(./obj_dir/avr_exec_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

/* tb/avr_exec_model.svh */
`ifndef AVR_EXEC_MODEL_SVH
`define AVR_EXEC_MODEL_SVH

// Register-register opcodes sit in bits [15:10]. LDI is 1110 in bits [15:12].
localparam logic [5:0] OP_ADD = 6'b0000_11;
localparam logic [5:0] OP_ADC = 6'b0001_11;
localparam logic [5:0] OP_SUB = 6'b0001_10;
localparam logic [5:0] OP_AND = 6'b0010_00;
localparam logic [5:0] OP_EOR = 6'b0010_01;
localparam logic [5:0] OP_OR  = 6'b0010_10;
localparam logic [5:0] OP_MOV = 6'b0010_11;

logic [7:0] shadow_regs [32];                      // Expected register contents.
avr_flags_t shadow_flags;                          // Expected C, Z, N.

function automatic void reset_shadow();
    for (int i = 0; i < 32; i++) begin
        shadow_regs[i] = 8'(255 - i);              // Power-up pattern.
    end
    shadow_flags = '0;
endfunction

// Executes one word in program order. Returns 1 when it retires with a result.
function automatic bit apply_word(input logic [15:0] w, output avr_result_t r);
    logic [4:0] d;
    logic [7:0] a;
    logic [7:0] b;
    logic [8:0] wide;                              // Bit 8 is carry or borrow.
    logic       upd;
    d    = w[8:4];
    a    = shadow_regs[w[8:4]];
    b    = shadow_regs[{w[9], w[3:0]}];
    upd  = 1'b1;
    r    = '0;
    wide = '0;
    if (w[15:12] == 4'b1110) begin
        d    = {1'b1, w[7:4]};                     // r16 to r31 only.
        wide = {1'b0, w[11:8], w[3:0]};
        upd  = 1'b0;
    end else begin
        case (w[15:10])
            OP_ADD:  wide = {1'b0, a} + {1'b0, b};
            OP_ADC:  wide = {1'b0, a} + {1'b0, b} + {8'h00, shadow_flags.c};
            OP_SUB:  wide = {1'b0, a} - {1'b0, b};
            OP_AND:  wide = {1'b0, a & b};         // Logic group ends with C clear.
            OP_OR:   wide = {1'b0, a | b};
            OP_EOR:  wide = {1'b0, a ^ b};
            OP_MOV: begin
                wide = {1'b0, b};
                upd  = 1'b0;                       // Flags untouched.
            end
            default: return 1'b0;                  // Dropped without a result.
        endcase
    end
    if (upd) begin
        shadow_flags.c = wide[8];
        shadow_flags.z = (wide[7:0] == 8'h00);
        shadow_flags.n = wide[7];
    end
    shadow_regs[d] = wide[7:0];
    r.rd    = d;
    r.value = wide[7:0];
    r.flags = shadow_flags;                        // Flags after this instruction.
    return 1'b1;
endfunction

`endif

/* tb/avr_exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module avr_exec_tb;
    import avr_dp_pkg::*;

    localparam int HALF_PERIOD = 20;               // 40 ns clock.
    localparam int N_RANDOM    = 300;              // Words in the back-pressure run.

    logic        clk = 1'b0;
    logic        arst_n;
    logic        insn_valid;
    logic        insn_ready;
    logic [15:0] insn;
    logic        out_valid;
    avr_result_t out;
    logic        out_ready = 1'b0;
    logic        ready_random = 1'b0;              // Random out_ready while set.
    int          cur_test;                         // Test that owns the word on insn.
    int          n_words = 0;
    logic [15:0] stim_word [$];
    int unsigned stim_gap [$];                     // Idle cycles after each word.
    int          stim_test [$];
    avr_result_t exp_q [$];                        // Expected results, oldest first.
    int          exp_test_q [$];
    avr_result_t head_value;                       // Oldest expected entry, moves at the edge.
    int          head_test;
    logic        head_avail = 1'b0;

    `include "avr_exec_model.svh"

    avr_exec_top #(
        .DATA_WIDTH  (REG_DATA_W),
        .ADDR_WIDTH  (REG_ADDR_W),
        .QUEUE_DEPTH (4)
    ) DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .insn_valid (insn_valid),
        .insn_ready (insn_ready),
        .insn       (insn),
        .out_valid  (out_valid),
        .out        (out),
        .out_ready  (out_ready)
    );

    always #HALF_PERIOD clk = ~clk;

    function automatic string test_name(input int id);
        case (id)
            1:       return "init_ldi_mov";
            2:       return "arith_flags";
            3:       return "logic_ops";
            4:       return "dependent_chain";
            5:       return "backpressure_random";
            6:       return "illegal_words";
            default: return "unknown";
        endcase
    endfunction

    function automatic logic [15:0] rr_word(input logic [5:0] op, input logic [4:0] d,
                                            input logic [4:0] r);
        return {op, r[4], d, r[3:0]};              // r bit 4 sits at bit 9.
    endfunction

    function automatic logic [15:0] ldi_word(input logic [4:0] d, input logic [7:0] k);
        return {4'b1110, k[7:4], d[3:0], k[3:0]};
    endfunction

    function automatic logic [5:0] pick_opcode(input int unsigned k);
        case (k % 7)
            0:       return OP_ADD;
            1:       return OP_ADC;
            2:       return OP_SUB;
            3:       return OP_AND;
            4:       return OP_OR;
            5:       return OP_EOR;
            default: return OP_MOV;
        endcase
    endfunction

    function automatic void queue_word(input int test, input logic [15:0] w,
                                       input int unsigned gap = 0);
        stim_word.push_back(w);
        stim_gap.push_back(gap);
        stim_test.push_back(test);
    endfunction

    function automatic void build_directed();
        queue_word(1, rr_word(OP_MOV, 5'd0, 5'd5));     // Untouched r5 reads 250.
        queue_word(1, rr_word(OP_MOV, 5'd1, 5'd31));
        queue_word(1, ldi_word(5'd16, 8'h5A));
        queue_word(1, rr_word(OP_MOV, 5'd2, 5'd16));    // Immediate read back.
        queue_word(2, ldi_word(5'd17, 8'hFF));
        queue_word(2, ldi_word(5'd18, 8'h01));
        queue_word(2, rr_word(OP_ADD, 5'd17, 5'd18));   // Wraps to zero with carry.
        queue_word(2, rr_word(OP_ADC, 5'd19, 5'd18));   // Carry pulled in.
        queue_word(2, rr_word(OP_ADD, 5'd4, 5'd5));
        queue_word(2, rr_word(OP_SUB, 5'd20, 5'd20));   // Zero result.
        queue_word(2, rr_word(OP_SUB, 5'd22, 5'd21));   // Borrow, leaves C set.
        queue_word(3, rr_word(OP_AND, 5'd23, 5'd24));   // Clears the C left above.
        queue_word(3, rr_word(OP_OR, 5'd24, 5'd23));
        queue_word(3, rr_word(OP_EOR, 5'd25, 5'd25));
        queue_word(3, rr_word(OP_MOV, 5'd9, 5'd23));    // Z from EOR survives.
        queue_word(3, ldi_word(5'd26, 8'h81));
        queue_word(4, rr_word(OP_ADD, 5'd10, 5'd11));
        queue_word(4, rr_word(OP_ADD, 5'd10, 5'd10));   // Needs the value just written.
        queue_word(4, rr_word(OP_SUB, 5'd12, 5'd10));
        queue_word(4, rr_word(OP_EOR, 5'd12, 5'd10));
        queue_word(4, rr_word(OP_MOV, 5'd13, 5'd12));
        queue_word(6, 16'h0000);                        // NOP.
        queue_word(6, rr_word(OP_ADD, 5'd14, 5'd15));
        queue_word(6, 16'hFFFF);
        queue_word(6, 16'h1400);                        // CP, not supported.
        queue_word(6, rr_word(OP_ADD, 5'd14, 5'd14));
    endfunction

    function automatic void build_random();
        logic [4:0]  d;
        logic [4:0]  s;
        int unsigned sel;
        for (int n = 0; n < N_RANDOM; n++) begin
            sel = $urandom % 10;
            d   = 5'($urandom);
            s   = 5'($urandom);
            if (sel == 0) begin
                queue_word(5, 16'($urandom), $urandom % 3);   // Mostly illegal.
            end else if (sel < 3) begin
                queue_word(5, ldi_word(d, 8'($urandom)), $urandom % 3);
            end else begin
                queue_word(5, rr_word(pick_opcode($urandom), d, s), $urandom % 3);
            end
        end
    endfunction

    // Consumer side, random only during the back-pressure run.
    always @(posedge clk) begin
        #2;
        if (ready_random) begin
            out_ready <= ($urandom % 32'd2) == 32'd1;
        end else begin
            out_ready <= 1'b1;
        end
    end

    // Shadow model follows every accepted word and every retired result.
    always @(posedge clk) begin : model_update
        avr_result_t r;
        if (arst_n) begin
            if (out_valid && out_ready && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
                void'(exp_test_q.pop_front());
            end
            if (insn_valid && insn_ready) begin
                if (apply_word(insn, r)) begin
                    exp_q.push_back(r);
                    exp_test_q.push_back(cur_test);
                end
            end
            head_avail <= (exp_q.size() != 0);
            if (exp_q.size() != 0) begin
                head_value <= exp_q[0];
                head_test  <= exp_test_q[0];
            end
        end
    end

    check_result: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && out_ready |-> head_avail && out == head_value)
        else begin
            if (!$sampled(head_avail)) begin
                $display("ERROR: a result came out with no instruction pending, got %h.",
                         $sampled(out));
            end else begin
                $display("MISMATCH %s: expected %h, actual %h", test_name($sampled(head_test)),
                         $sampled(head_value), $sampled(out));
            end
            $display("*** FAILED ***");
            $fatal(1, "Result check failed.");
        end

    // Budget of 20 cycles per word on top of reset and drain.
    initial begin
        wait (n_words != 0);
        repeat (10 + n_words * 20 + 200) @(posedge clk);
        $display("ERROR: run hung, watchdog expired with %0d results outstanding.",
                 exp_q.size());
        $display("*** FAILED ***");
        $fatal(1, "Watchdog expired.");
    end

    initial begin
        int drain;
        arst_n     = 1'b0;
        insn_valid = 1'b0;
        insn       = '0;
        cur_test   = 0;
        void'($urandom(32'hae29ea9f));
        reset_shadow();
        build_directed();
        build_random();
        n_words = stim_word.size();
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;
        for (int i = 0; i < n_words; i++) begin
            cur_test     = stim_test[i];
            ready_random = (stim_test[i] == 5);
            insn_valid   = 1'b1;
            insn         = stim_word[i];
            @(posedge clk);
            while (!insn_ready) begin
                @(posedge clk);                    // Valid holds until taken.
            end
            #2;
            insn_valid = 1'b0;
            repeat (stim_gap[i]) begin
                @(posedge clk);
                #2;
            end
        end
        drain = 0;
        while (exp_q.size() != 0 && drain < 200) begin
            @(posedge clk);
            #2;
            drain++;
        end
        repeat (10) @(posedge clk);                // Catch any stray extra result.
        if (exp_q.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("ERROR: %0d expected results never came out.", exp_q.size());
            $display("*** FAILED ***");
            $fatal(1, "Missing results.");
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+tb
hw/avr_isa_pkg.sv
hw/avr_dp_pkg.sv
hw/insn_decoder.sv
hw/dual_port_sram.sv
hw/alu_core.sv
hw/result_queue.sv
hw/avr_exec_top.sv
tb/avr_exec_tb.sv
